//--- design/mem_pkg.sv
//------------------------------
// shared types for the banked memory subsystem
// byte addresses, 64-bit data words, single-beat requests
// payload is one 72-bit word read as write or read view
// depending on is_read
//------------------------------

package mem_pkg;

   // widths
   localparam int ADDR_W = 32;
   localparam int ID_W = 8;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;
   localparam int PAYLOAD_W = DATA_W + STRB_W;

   // write view: data word plus byte strobes
   typedef struct packed {
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } wr_payload_t;

   // read view: only the size field carries meaning
   typedef struct packed {
      logic [PAYLOAD_W-4:0] rsvd;
      logic [2:0] rsize;
   } rd_payload_t;

   typedef union packed {
      wr_payload_t wr;
      rd_payload_t rd;
   } mem_payload_u;

   typedef struct packed {
      logic is_read;
      logic [ID_W-1:0] id;
      logic [ADDR_W-1:0] addr;
      mem_payload_u payload;
   } mem_req_t;

   // rdata is zero on a write acknowledge
   typedef struct packed {
      logic is_read;
      logic [ID_W-1:0] id;
      logic [DATA_W-1:0] rdata;
   } mem_resp_t;

endpackage

//--- design/req_router.sv
//------------------------------
// request router with per-bank credits
// bank select is addr[3 +: log2(NUM_BANKS)]
// NUM_BANKS must be a power of two, at least 2
// one credit per bank queue slot, QDEPTH after reset
// bank ports are registered, one cycle per request
//------------------------------

`timescale 1ns/1ps

module req_router #(
   parameter int NUM_BANKS = 4,
   parameter int QDEPTH = 4
) (
   input logic clk,
   input logic rstn,
   input logic req_valid,
   input mem_pkg::mem_req_t req,
   output logic req_ready,
   input logic [NUM_BANKS-1:0] credit_ret,
   output logic [NUM_BANKS-1:0] bank_req_valid,
   output mem_pkg::mem_req_t bank_req [NUM_BANKS]
);

   localparam int BANK_BITS = $clog2(NUM_BANKS);
   localparam int CRED_W = $clog2(QDEPTH + 1);

   logic [BANK_BITS-1:0] tgt;
   logic [CRED_W-1:0] credit [NUM_BANKS];
   logic accept;
   logic [NUM_BANKS-1:0] take;

   // word interleave: low bank bits just above the byte offset
   assign tgt = req.addr[3 +: BANK_BITS];

   // ready only depends on the target bank credit
   assign req_ready = (credit[tgt] != '0);
   assign accept = req_valid && req_ready;

   // one-hot of the bank that takes this request
   always_comb begin
      take = '0;
      if (accept) begin
         take[tgt] = 1'b1;
      end
   end

   // valids and credit counters
   always_ff @(posedge clk) begin
      if (!rstn) begin
         bank_req_valid <= '0;
         for (int b = 0; b < NUM_BANKS; b++) begin
            credit[b] <= CRED_W'(QDEPTH);
         end
      end else begin
         bank_req_valid <= take;
         for (int b = 0; b < NUM_BANKS; b++) begin
            // take and return in one cycle cancel out
            credit[b] <= credit[b] - CRED_W'(take[b]) + CRED_W'(credit_ret[b]);
         end
      end
   end

   // request payload, only the target bank port loads
   always_ff @(posedge clk) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (take[b]) begin
            bank_req[b] <= req;
         end
      end
   end

endmodule

//--- design/mem_bank.sv
//------------------------------
// one memory bank with fixed latency queue
// QDEPTH must be at least 2, caller holds a credit per push
// word RAM has no reset, unwritten words read undefined
// stamps are 32-bit and compared modulo, so a head
// must not wait 2^32 cycles
//------------------------------

`timescale 1ns/1ps

module mem_bank #(
   parameter int NUM_BANKS = 4,
   parameter int BANK_WORDS = 64,
   parameter int QDEPTH = 4,
   parameter int LATENCY = 8
) (
   input logic clk,
   input logic rstn,
   input logic in_valid,
   input mem_pkg::mem_req_t in_req,
   output logic head_valid,
   output mem_pkg::mem_resp_t head_resp,
   input logic pop
);

   import mem_pkg::*;

   localparam int BANK_BITS = $clog2(NUM_BANKS);
   localparam int WORD_BITS = $clog2(BANK_WORDS);
   localparam int PTR_W = $clog2(QDEPTH);
   localparam int CNT_W = $clog2(QDEPTH + 1);
   localparam int STAMP_W = 32;

   // queue storage
   mem_req_t q_req [QDEPTH];
   logic [STAMP_W-1:0] q_stamp [QDEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [STAMP_W-1:0] cycle_cnt;

   logic [DATA_W-1:0] ram [BANK_WORDS];

   mem_req_t head;
   logic [WORD_BITS-1:0] head_word;
   logic [DATA_W-1:0] ram_word;
   logic [STAMP_W-1:0] age;
   logic [3:0] keep_bytes;
   logic [DATA_W-1:0] rd_masked;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(QDEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // free-running stamp source
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

   // queue pointers and occupancy
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (in_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CNT_W'(in_valid) - CNT_W'(pop);
      end
   end

   // entry payload and stamp
   always_ff @(posedge clk) begin
      if (in_valid) begin
         q_req[wr_ptr] <= in_req;
         q_stamp[wr_ptr] <= cycle_cnt;
      end
   end

   assign head = q_req[rd_ptr];
   // bank bits skipped, upper word bits dropped
   assign head_word = head.addr[3 + BANK_BITS +: WORD_BITS];
   assign ram_word = ram[head_word];
   assign age = cycle_cnt - q_stamp[rd_ptr];

   // write lands when the arbiter takes the ack
   always_ff @(posedge clk) begin
      if (pop && !head.is_read) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (head.payload.wr.wstrb[i]) begin
               ram[head_word][i*8 +: 8] <= head.payload.wr.wdata[i*8 +: 8];
            end
         end
      end
   end

   // read size mask, 2**rsize bytes capped at a full word
   always_comb begin
      keep_bytes = (head.payload.rd.rsize >= 3'd3) ? 4'd8 : (4'd1 << head.payload.rd.rsize);
      for (int i = 0; i < STRB_W; i++) begin
         rd_masked[i*8 +: 8] = (i < int'(keep_bytes)) ? ram_word[i*8 +: 8] : 8'h00;
      end
   end

   assign head_valid = (count != '0) && (age >= STAMP_W'(LATENCY));

   always_comb begin
      head_resp.is_read = head.is_read;
      head_resp.id = head.id;
      head_resp.rdata = head.is_read ? rd_masked : '0;
   end

endmodule

//--- design/resp_arbiter.sv
//------------------------------
// round-robin response arbiter
// NUM_BANKS must be a power of two, at least 2
// grant doubles as bank pop and credit return
// output register holds while not taken
//------------------------------

`timescale 1ns/1ps

module resp_arbiter #(
   parameter int NUM_BANKS = 4
) (
   input logic clk,
   input logic rstn,
   input logic [NUM_BANKS-1:0] head_valid,
   input mem_pkg::mem_resp_t head_resp [NUM_BANKS],
   output logic [NUM_BANKS-1:0] grant,
   output logic resp_valid,
   output mem_pkg::mem_resp_t resp,
   input logic resp_ready
);

   localparam int BANK_BITS = $clog2(NUM_BANKS);

   logic [BANK_BITS-1:0] rr_ptr;
   logic [BANK_BITS-1:0] sel;
   logic found;
   logic can_load;

   // empty or being drained this cycle
   assign can_load = !resp_valid || resp_ready;

   // first ready bank at or after the pointer
   always_comb begin
      logic [BANK_BITS-1:0] idx;
      sel = '0;
      found = 1'b0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         // index wraps on its own, NUM_BANKS is a power of two
         idx = rr_ptr + BANK_BITS'(i);
         if (!found && head_valid[idx]) begin
            sel = idx;
            found = 1'b1;
         end
      end
   end

   always_comb begin
      grant = '0;
      if (found && can_load) begin
         grant[sel] = 1'b1;
      end
   end

   // control state
   always_ff @(posedge clk) begin
      if (!rstn) begin
         resp_valid <= 1'b0;
         rr_ptr <= '0;
      end else if (grant != '0) begin
         resp_valid <= 1'b1;
         // next search starts past the winner
         rr_ptr <= sel + 1'b1;
      end else if (resp_ready) begin
         resp_valid <= 1'b0;
      end
   end

   // response payload
   always_ff @(posedge clk) begin
      if (grant != '0) begin
         resp <= head_resp[sel];
      end
   end

endmodule

//--- design/mem_subsys.sv
//------------------------------
// banked fixed-latency memory subsystem
// NUM_BANKS power of two, at least 2
// QDEPTH at least 2, LATENCY in cycles
// first response LATENCY+2 cycles after accept
// per-bank order kept, banks may reorder
//------------------------------

`timescale 1ns/1ps

module mem_subsys #(
   parameter int NUM_BANKS = 4,
   parameter int BANK_WORDS = 64,
   parameter int QDEPTH = 4,
   parameter int LATENCY = 8
) (
   input logic clk,
   input logic rstn,
   input logic req_valid,
   input mem_pkg::mem_req_t req,
   output logic req_ready,
   output logic resp_valid,
   output mem_pkg::mem_resp_t resp,
   input logic resp_ready
);

   import mem_pkg::*;

   // router to banks
   logic [NUM_BANKS-1:0] bank_req_valid;
   mem_req_t bank_req [NUM_BANKS];

   // banks to arbiter, grant goes back as pop and credit
   logic [NUM_BANKS-1:0] head_valid;
   mem_resp_t head_resp [NUM_BANKS];
   logic [NUM_BANKS-1:0] grant;

   req_router #(
      .NUM_BANKS(NUM_BANKS),
      .QDEPTH(QDEPTH)
   ) router_i (
      .clk(clk),
      .rstn(rstn),
      .req_valid(req_valid),
      .req(req),
      .req_ready(req_ready),
      .credit_ret(grant),
      .bank_req_valid(bank_req_valid),
      .bank_req(bank_req)
   );

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      mem_bank #(
         .NUM_BANKS(NUM_BANKS),
         .BANK_WORDS(BANK_WORDS),
         .QDEPTH(QDEPTH),
         .LATENCY(LATENCY)
      ) bank_i (
         .clk(clk),
         .rstn(rstn),
         .in_valid(bank_req_valid[b]),
         .in_req(bank_req[b]),
         .head_valid(head_valid[b]),
         .head_resp(head_resp[b]),
         .pop(grant[b])
      );
   end

   resp_arbiter #(
      .NUM_BANKS(NUM_BANKS)
   ) arbiter_i (
      .clk(clk),
      .rstn(rstn),
      .head_valid(head_valid),
      .head_resp(head_resp),
      .grant(grant),
      .resp_valid(resp_valid),
      .resp(resp),
      .resp_ready(resp_ready)
   );

endmodule

//--- tb/mem_subsys_assert.sv
//------------------------------
// response port checks, bound into mem_subsys
// fail_count is read back by the testbench
//------------------------------

`timescale 1ns/1ps

module mem_subsys_assert (
   input logic clk,
   input logic rstn,
   input logic resp_valid,
   input mem_pkg::mem_resp_t resp,
   input logic resp_ready
);

   int fail_count = 0;

   // stalled response holds its value
   a_resp_hold: assert property (@(posedge clk) disable iff (!rstn)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp))
   else begin
      fail_count++;
      $error("resp changed while stalled");
   end

   a_resp_known: assert property (@(posedge clk) disable iff (!rstn)
      resp_valid |-> !$isunknown(resp))
   else begin
      fail_count++;
      $error("resp has unknown bits while valid");
   end

   // output register empty right after reset
   a_reset_idle: assert property (@(posedge clk) !rstn |=> !resp_valid)
   else begin
      fail_count++;
      $error("resp_valid high after reset");
   end

endmodule

bind mem_subsys mem_subsys_assert assert_i (
   .clk(clk),
   .rstn(rstn),
   .resp_valid(resp_valid),
   .resp(resp),
   .resp_ready(resp_ready)
);

//--- tb/tb_mem_subsys.sv
//------------------------------
// directed testbench for mem_subsys
// reference memory spans every bank word once
// reads only target bytes written earlier in the run
// ids wrap at 256, far above the outstanding limit
//------------------------------

`timescale 1ns/1ps

module tb_mem_subsys;

   import mem_pkg::*;

   localparam int NUM_BANKS = 4;
   localparam int BANK_WORDS = 64;
   localparam int QDEPTH = 4;
   localparam int LATENCY = 8;
   localparam int MEM_BYTES = NUM_BANKS * BANK_WORDS * 8;
   localparam int N_RAND = 200;
   // 8, 3, 3, QDEPTH+2 and N_RAND requests, plus reset
   localparam int N_REQS = 14 + QDEPTH + 2 + N_RAND;
   localparam int CYCLE_LIMIT = 16 + N_REQS * (LATENCY + NUM_BANKS * QDEPTH + 10);

   logic clk;
   logic rstn;
   logic req_valid;
   mem_req_t req;
   logic req_ready;
   logic resp_valid;
   mem_resp_t resp;
   logic resp_ready;

   logic [31:0] lcg_state;
   logic [ID_W-1:0] next_id;
   int err_cnt;
   int fail_cnt;
   int cycle_cnt;
   int outstanding;
   bit rand_ready;

   // byte-level reference, expectations kept by id
   logic [7:0] ref_mem [MEM_BYTES];
   bit ref_known [MEM_BYTES];
   mem_resp_t exp_resp [256];
   bit exp_pend [256];
   int exp_bank [256];
   int exp_seq [256];
   int issue_cnt [NUM_BANKS];
   int done_cnt [NUM_BANKS];

   mem_subsys #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS),
                .QDEPTH(QDEPTH), .LATENCY(LATENCY)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // word interleave, bank in the low word bits
   function automatic logic [ADDR_W-1:0] word_addr(input int bank, input int word);
      return ADDR_W'((word * NUM_BANKS + bank) * 8);
   endfunction

   // for reads the low 3 bits of strb_or_size give rsize
   function automatic mem_req_t make_req(input logic rd, input int bank, input int word,
                                         input logic [63:0] wdata, input logic [7:0] strb_or_size);
      mem_req_t r;
      r.is_read = rd;
      r.id = next_id;
      r.addr = word_addr(bank, word);
      r.payload.wr.wdata = wdata;
      r.payload.wr.wstrb = strb_or_size;
      if (rd) begin
         r.payload = '0;
         r.payload.rd.rsize = strb_or_size[2:0];
      end
      next_id = next_id + 1'b1;
      return r;
   endfunction

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic compare_resp(input mem_resp_t got, input mem_resp_t exp);
      if (got !== exp) begin
         $display("ERR %0t resp got %h expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   // accepted request updates the reference and the expected table
   task automatic record(input mem_req_t r);
      int base;
      int nbytes;
      mem_resp_t e;
      base = int'(r.addr);
      e.is_read = r.is_read;
      e.id = r.id;
      e.rdata = '0;
      if (r.is_read) begin
         // 2**rsize bytes, never more than a word
         case (r.payload.rd.rsize)
            3'd0: nbytes = 1;
            3'd1: nbytes = 2;
            3'd2: nbytes = 4;
            default: nbytes = 8;
         endcase
         for (int i = 0; i < nbytes; i++) begin
            e.rdata[i*8 +: 8] = ref_mem[base + i];
         end
      end else begin
         for (int i = 0; i < STRB_W; i++) begin
            if (r.payload.wr.wstrb[i]) begin
               ref_mem[base + i] = r.payload.wr.wdata[i*8 +: 8];
               ref_known[base + i] = 1'b1;
            end
         end
      end
      exp_resp[r.id] = e;
      exp_pend[r.id] = 1'b1;
      exp_bank[r.id] = (base / 8) % NUM_BANKS;
      exp_seq[r.id] = issue_cnt[exp_bank[r.id]];
      issue_cnt[exp_bank[r.id]]++;
      outstanding++;
   endtask

   // one cycle offer, ready sampled at the rising edge
   task automatic try_send(input mem_req_t r, output bit accepted);
      logic [31:0] rnd;
      @(negedge clk);
      req_valid = 1'b1;
      req = r;
      if (rand_ready) begin
         rnd = lcg_next();
         resp_ready = rnd[16];
      end
      @(posedge clk);
      accepted = req_ready;
      if (accepted) begin
         record(r);
      end
   endtask

   task automatic send(input mem_req_t r);
      bit ok;
      ok = 1'b0;
      while (!ok) begin
         try_send(r, ok);
      end
   endtask

   // release responses and wait for every outstanding id
   task automatic drain();
      @(negedge clk);
      req_valid = 1'b0;
      resp_ready = 1'b1;
      while (outstanding != 0) begin
         @(negedge clk);
      end
   endtask

   // response monitor, checks value, id and per-bank order
   always @(posedge clk) begin
      if (rstn && resp_valid && resp_ready) begin
         if (!exp_pend[resp.id]) begin
            $display("response with id %0d arrived but none was expected", resp.id);
            fail_cnt++;
         end else begin
            compare_resp(resp, exp_resp[resp.id]);
            if (exp_seq[resp.id] != done_cnt[exp_bank[resp.id]]) begin
               $display("bank %0d returned id %0d out of request order",
                        exp_bank[resp.id], resp.id);
               fail_cnt++;
            end
            done_cnt[exp_bank[resp.id]]++;
            exp_pend[resp.id] = 1'b0;
            outstanding--;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic idle_after_reset();
      @(negedge clk);
      compare_bit("req_ready", req_ready, 1'b1);
      compare_bit("resp_valid", resp_valid, 1'b0);
   endtask

   // full word write then read back, each bank
   task automatic write_then_read();
      for (int b = 0; b < NUM_BANKS; b++) begin
         send(make_req(1'b0, b, 1, {lcg_next(), lcg_next()}, 8'hff));
         send(make_req(1'b1, b, 1, '0, 8'd3));
      end
      drain();
   endtask

   // disjoint strobes merge into one word
   task automatic merge_strobes();
      send(make_req(1'b0, 2, 5, {lcg_next(), lcg_next()}, 8'h0f));
      send(make_req(1'b0, 2, 5, {lcg_next(), lcg_next()}, 8'hf0));
      send(make_req(1'b1, 2, 5, '0, 8'd3));
      drain();
   endtask

   // 1, 2 and 4 byte reads of a word from write_then_read
   task automatic read_size_mask();
      for (int s = 0; s < 3; s++) begin
         send(make_req(1'b1, 1, 1, '0, 8'(s)));
      end
      drain();
   endtask

   task automatic backpressure_one_bank();
      bit ok;
      @(negedge clk);
      resp_ready = 1'b0;
      // alternate write and read on one word of bank 0
      // each must go in on its first offer
      for (int q = 0; q < QDEPTH; q++) begin
         try_send(make_req(q[0], 0, 2, {lcg_next(), lcg_next()}, q[0] ? 8'd3 : 8'hff), ok);
         compare_bit("req_ready", ok, 1'b1);
      end
      // bank 0 out of credits, bank 1 still open
      try_send(make_req(1'b1, 0, 2, '0, 8'd3), ok);
      compare_bit("req_ready", ok, 1'b0);
      try_send(make_req(1'b0, 1, 2, {lcg_next(), lcg_next()}, 8'hff), ok);
      compare_bit("req_ready", ok, 1'b1);
      drain();
   endtask

   task automatic random_traffic();
      logic [31:0] rnd;
      int bank;
      int word;
      bit known;
      rand_ready = 1'b1;
      for (int n = 0; n < N_RAND; n++) begin
         rnd = lcg_next();
         bank = int'(rnd[15:8]) % NUM_BANKS;
         // small window so reads hit earlier writes
         word = int'(rnd[23:16]) % 8;
         known = 1'b1;
         for (int i = 0; i < 8; i++) begin
            known = known && ref_known[int'(word_addr(bank, word)) + i];
         end
         if (known && rnd[7]) begin
            send(make_req(1'b1, bank, word, '0, {5'd0, rnd[6:4]}));
         end else begin
            send(make_req(1'b0, bank, word, {lcg_next(), lcg_next()},
                          known ? rnd[31:24] : 8'hff));
         end
      end
      rand_ready = 1'b0;
      drain();
   endtask

   initial begin
      int asrt_fail;
      lcg_state = 32'h993f3554;
      next_id = '0;
      err_cnt = 0;
      fail_cnt = 0;
      cycle_cnt = 0;
      outstanding = 0;
      rand_ready = 1'b0;
      rstn = 1'b0;
      req_valid = 1'b0;
      req = '0;
      resp_ready = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      idle_after_reset();
      write_then_read();
      merge_strobes();
      read_size_mask();
      backpressure_one_bank();
      random_traffic();
      asrt_fail = dut_i.assert_i.fail_count;
      $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
               err_cnt, fail_cnt, asrt_fail);
      if (err_cnt == 0 && fail_cnt == 0 && asrt_fail == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
design/mem_pkg.sv
design/req_router.sv
design/mem_bank.sv
design/resp_arbiter.sv
design/mem_subsys.sv
tb/mem_subsys_assert.sv
tb/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, verdict taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f src.f \
   && ./obj_dir/Vtb_mem_subsys 2>&1 | tee sim.log \
   || echo "build or run did not complete"
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
